/* design/eth_macros.svh */
`ifndef ETH_MACROS_SVH
`define ETH_MACROS_SVH

// ########################################
// Frame geometry
// ########################################

// Count of 0x55 bytes sent ahead of the SFD byte
`define ETH_PREAMBLE_LEN 7
`define ETH_PAYLOAD_LEN 32

// ########################################
// Burst geometry and buffering
// ########################################

`define ETH_BURST_FRAMES 4
`define ETH_GAP_CYCLES 32
`define ETH_FIFO_DEPTH 64

`endif

/* design/eth_pkg.sv */
`default_nettype none

package eth_pkg;

    typedef logic [7:0] byte_t;

    // One received payload byte as it sits in the rx FIFO
    typedef struct packed {
        byte_t data;
        logic  last;   // Final payload byte of its frame
    } rx_beat_t;

    typedef enum logic [2:0] {IDLE, FILL, SEND, GAP, DONE} seq_state_t;

    // Register value left behind by a frame whose FCS is intact
    localparam logic [31:0] CRC32_RESIDUE = 32'hDEBB20E3;

    // Reflected CRC-32, one byte per call, LSB of the byte first
    function automatic logic [31:0] crc32_step(input logic [31:0] crc, input byte_t data);
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ data[i])
                c = (c >> 1) ^ 32'hEDB88320;
            else
                c = c >> 1;
        end
        return c;
    endfunction

endpackage

`default_nettype wire

/* design/byte_fifo.sv */
`default_nettype none
`timescale 1ns/1ps
`include "eth_macros.svh"

module byte_fifo import eth_pkg::*; #(
    parameter type entry_t = byte_t
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   wr_valid,
    output logic   wr_ready,
    input  entry_t wr_data,
    output logic   rd_valid,
    input  logic   rd_ready,
    output entry_t rd_data
);

    localparam int DEPTH = `ETH_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    entry_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_wr;
    logic          do_rd;

    assign wr_ready = count != (AW+1)'(DEPTH);
    assign rd_valid = count != '0;
    assign rd_data  = mem[rd_ptr];   // Head entry is visible without a read strobe
    assign do_wr    = wr_valid && wr_ready;
    assign do_rd    = rd_valid && rd_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;   // Pointers wrap since DEPTH is a power of two
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_ptr] <= wr_data;
    end

endmodule

`default_nettype wire

/* design/payload_filler.sv */
`default_nettype none
`timescale 1ns/1ps
`include "eth_macros.svh"

module payload_filler import eth_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       fill_req,
    input  logic [1:0] fill_index,
    output logic       fill_ack,
    input  byte_t      pattern_base,
    output logic       wr_valid,
    input  logic       wr_ready,
    output byte_t      wr_data
);

    localparam int CW = $clog2(`ETH_PAYLOAD_LEN);

    logic          busy;
    logic          start;
    logic          last_beat;
    logic [CW-1:0] beat_cnt;

    // A new request is only taken once the previous ack has dropped
    assign start     = fill_req && !busy && !fill_ack;
    assign last_beat = beat_cnt == CW'(`ETH_PAYLOAD_LEN - 1);
    assign wr_valid  = busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            fill_ack <= 1'b0;
            beat_cnt <= '0;
        end else if (busy) begin
            if (wr_ready) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (last_beat) begin
                    busy     <= 1'b0;
                    fill_ack <= 1'b1;
                end
            end
        end else if (fill_ack) begin
            if (!fill_req) fill_ack <= 1'b0;
        end else if (start) begin
            busy     <= 1'b1;
            beat_cnt <= '0;
        end
    end

    // Frame k starts k payloads above the base and counts up by one
    always_ff @(posedge clk) begin
        if (start)
            wr_data <= pattern_base + byte_t'(fill_index * `ETH_PAYLOAD_LEN);
        else if (busy && wr_ready)
            wr_data <= wr_data + 8'd1;
    end

endmodule

`default_nettype wire

/* design/mac_tx.sv */
`default_nettype none
`timescale 1ns/1ps
`include "eth_macros.svh"

module mac_tx import eth_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  send_req,
    output logic  send_ack,
    input  logic  rd_valid,
    output logic  rd_ready,
    input  byte_t rd_data,
    output byte_t txd,
    output logic  tx_en
);

    typedef enum logic [2:0] {TX_IDLE, TX_PRE, TX_LEN, TX_PAY, TX_CRC, TX_ACK} tx_state_t;

    localparam logic [15:0] LEN_FIELD = 16'(`ETH_PAYLOAD_LEN);
    localparam logic [5:0]  PRE_LAST  = 6'(`ETH_PREAMBLE_LEN);   // SFD follows the preamble
    localparam logic [5:0]  PAY_LAST  = 6'(`ETH_PAYLOAD_LEN - 1);

    tx_state_t   state;
    logic [5:0]  cnt;
    logic [31:0] crc;
    byte_t       len_byte;
    byte_t       tx_byte;

    assign rd_ready = state == TX_PAY;
    assign len_byte = cnt[0] ? LEN_FIELD[7:0] : LEN_FIELD[15:8];

    // ########################################
    // Byte to put on the wire next cycle
    // ########################################

    always_comb begin
        case (state)
            TX_PRE:  tx_byte = (cnt == PRE_LAST) ? 8'hD5 : 8'h55;
            TX_LEN:  tx_byte = len_byte;
            TX_PAY:  tx_byte = rd_data;
            TX_CRC:  tx_byte = ~crc[8*cnt[1:0] +: 8];   // FCS goes out low byte first
            default: tx_byte = 8'h00;
        endcase
    end

    // ########################################
    // Frame sequencing
    // ########################################

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= TX_IDLE;
            cnt      <= '0;
            txd      <= 8'h00;
            tx_en    <= 1'b0;
            send_ack <= 1'b0;
        end else begin
            txd   <= tx_byte;
            tx_en <= state inside {TX_PRE, TX_LEN, TX_PAY, TX_CRC};
            cnt   <= cnt + 6'd1;
            case (state)
                TX_IDLE: begin
                    cnt <= '0;
                    if (send_req && rd_valid) state <= TX_PRE;
                end
                TX_PRE: begin
                    if (cnt == PRE_LAST) begin
                        state <= TX_LEN;
                        cnt   <= '0;
                    end
                end
                TX_LEN: begin
                    if (cnt == 6'd1) begin
                        state <= TX_PAY;
                        cnt   <= '0;
                    end
                end
                TX_PAY: begin
                    if (cnt == PAY_LAST) begin
                        state <= TX_CRC;
                        cnt   <= '0;
                    end
                end
                TX_CRC: begin
                    if (cnt == 6'd3) state <= TX_ACK;
                end
                TX_ACK: begin
                    // Ack comes up together with tx_en going low
                    if (!send_req) begin
                        send_ack <= 1'b0;
                        state    <= TX_IDLE;
                    end else begin
                        send_ack <= 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Running CRC over the length field and the payload
    always_ff @(posedge clk) begin
        if (state == TX_IDLE)
            crc <= '1;
        else if (state == TX_LEN || state == TX_PAY)
            crc <= crc32_step(crc, tx_byte);
    end

endmodule

`default_nettype wire

/* design/mac_rx.sv */
`default_nettype none
`timescale 1ns/1ps

module mac_rx import eth_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  byte_t    rxd,
    input  logic     rx_dv,
    output logic     wr_valid,
    input  logic     wr_ready,
    output rx_beat_t wr_data,
    output logic     frame_ok,
    output logic     frame_err
);

    typedef enum logic [2:0] {RX_HUNT, RX_PRE, RX_LEN, RX_BODY, RX_SKIP} rx_state_t;

    rx_state_t   state;
    logic [15:0] cnt;
    logic [15:0] len;
    logic [31:0] crc;
    logic        dropped;
    logic        frame_good;

    // Bytes past the length count are the FCS and stay out of the FIFO
    assign wr_valid     = state == RX_BODY && rx_dv && cnt < len;
    assign wr_data.data = rxd;
    assign wr_data.last = cnt == len - 16'd1;

    assign frame_good = crc == CRC32_RESIDUE && cnt == len + 16'd4 && !dropped;

    // ########################################
    // Frame parsing and status
    // ########################################

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= RX_HUNT;
            cnt       <= '0;
            dropped   <= 1'b0;
            frame_ok  <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            frame_ok  <= 1'b0;
            frame_err <= 1'b0;
            case (state)
                RX_HUNT: begin
                    if (rx_dv) state <= (rxd == 8'h55) ? RX_PRE : RX_SKIP;
                end
                RX_PRE: begin
                    if (!rx_dv) begin
                        state <= RX_HUNT;   // Runt preamble with nothing behind it
                    end else if (rxd == 8'hD5) begin
                        state   <= RX_LEN;
                        cnt     <= '0;
                        dropped <= 1'b0;
                    end else if (rxd != 8'h55) begin
                        state <= RX_SKIP;
                    end
                end
                RX_LEN: begin
                    if (!rx_dv) begin
                        frame_err <= 1'b1;
                        state     <= RX_HUNT;
                    end else if (cnt[0]) begin
                        state <= RX_BODY;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                RX_BODY: begin
                    if (rx_dv) begin
                        cnt <= cnt + 16'd1;
                        if (wr_valid && !wr_ready) dropped <= 1'b1;
                    end else begin
                        frame_ok  <= frame_good;
                        frame_err <= !frame_good;
                        state     <= RX_HUNT;
                    end
                end
                RX_SKIP: begin
                    // Garbage on the line still counts as one bad frame
                    if (!rx_dv) begin
                        frame_err <= 1'b1;
                        state     <= RX_HUNT;
                    end
                end
                default: state <= RX_HUNT;
            endcase
        end
    end

    // CRC covers everything after the SFD including the FCS itself
    always_ff @(posedge clk) begin
        if (state == RX_PRE)
            crc <= '1;
        else if (rx_dv && (state == RX_LEN || state == RX_BODY))
            crc <= crc32_step(crc, rxd);

        if (state == RX_LEN && rx_dv) begin
            if (cnt[0])
                len[7:0] <= rxd;
            else
                len[15:8] <= rxd;   // Length field arrives high byte first
        end
    end

endmodule

`default_nettype wire

/* design/burst_sequencer.sv */
`default_nettype none
`timescale 1ns/1ps
`include "eth_macros.svh"

module burst_sequencer import eth_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       burst_req,
    output logic       burst_ack,
    output logic       fill_req,
    output logic [1:0] fill_index,
    input  logic       fill_ack,
    output logic       send_req,
    input  logic       send_ack
);

    localparam int              GW         = $clog2(`ETH_GAP_CYCLES);
    localparam logic [GW-1:0]   GAP_LAST   = GW'(`ETH_GAP_CYCLES - 1);
    localparam logic [1:0]      LAST_FRAME = 2'(`ETH_BURST_FRAMES - 1);

    seq_state_t    state;
    logic [1:0]    frame_cnt;
    logic [GW-1:0] gap_cnt;
    logic          ack_seen;   // Set once the helper has acked the current request

    assign burst_ack  = state == DONE;
    assign fill_req   = state == FILL && !ack_seen;
    assign send_req   = state == SEND && !ack_seen;
    assign fill_index = frame_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            frame_cnt <= '0;
            gap_cnt   <= '0;
            ack_seen  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    frame_cnt <= '0;
                    if (burst_req) state <= FILL;
                end
                FILL: begin
                    if (fill_ack) begin
                        ack_seen <= 1'b1;
                    end else if (ack_seen) begin
                        ack_seen <= 1'b0;
                        state    <= SEND;
                    end
                end
                SEND: begin
                    if (send_ack) begin
                        ack_seen <= 1'b1;
                    end else if (ack_seen) begin
                        ack_seen <= 1'b0;
                        gap_cnt  <= '0;
                        state    <= GAP;
                    end
                end
                GAP: begin
                    gap_cnt <= gap_cnt + 1'b1;
                    if (gap_cnt == GAP_LAST) begin
                        if (frame_cnt == LAST_FRAME) begin
                            state <= DONE;
                        end else begin
                            frame_cnt <= frame_cnt + 2'd1;
                            state     <= FILL;
                        end
                    end
                end
                DONE: if (!burst_req) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/eth_loopback_top.sv */
`default_nettype none
`timescale 1ns/1ps

module eth_loopback_top import eth_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  burst_req,
    output logic  burst_ack,
    input  byte_t pattern_base,
    output byte_t txd,
    output logic  tx_en,
    input  byte_t rxd,
    input  logic  rx_dv,
    output byte_t rx_data,
    output logic  rx_last,
    output logic  rx_valid,
    input  logic  rx_ready,
    output logic  frame_ok,
    output logic  frame_err
);

    logic       fill_req, fill_ack, send_req, send_ack;
    logic [1:0] fill_index;
    logic       pay_wr_valid, pay_wr_ready, pay_rd_valid, pay_rd_ready;
    byte_t      pay_wr_data, pay_rd_data;
    logic       beat_wr_valid, beat_wr_ready;
    rx_beat_t   beat_wr_data, beat_rd_data;

    assign rx_data = beat_rd_data.data;
    assign rx_last = beat_rd_data.last;

    // ########################################
    // Transmit side
    // ########################################

    burst_sequencer burst_sequencer_inst (
        .clk, .rst, .burst_req, .burst_ack,
        .fill_req, .fill_index, .fill_ack, .send_req, .send_ack
    );

    payload_filler payload_filler_inst (
        .clk, .rst, .fill_req, .fill_index, .fill_ack, .pattern_base,
        .wr_valid(pay_wr_valid), .wr_ready(pay_wr_ready), .wr_data(pay_wr_data)
    );

    byte_fifo #(.entry_t(byte_t)) payload_fifo_inst (
        .clk, .rst,
        .wr_valid(pay_wr_valid), .wr_ready(pay_wr_ready), .wr_data(pay_wr_data),
        .rd_valid(pay_rd_valid), .rd_ready(pay_rd_ready), .rd_data(pay_rd_data)
    );

    mac_tx mac_tx_inst (
        .clk, .rst, .send_req, .send_ack,
        .rd_valid(pay_rd_valid), .rd_ready(pay_rd_ready), .rd_data(pay_rd_data),
        .txd, .tx_en
    );

    // ########################################
    // Receive side
    // ########################################

    mac_rx mac_rx_inst (
        .clk, .rst, .rxd, .rx_dv,
        .wr_valid(beat_wr_valid), .wr_ready(beat_wr_ready), .wr_data(beat_wr_data),
        .frame_ok, .frame_err
    );

    byte_fifo #(.entry_t(rx_beat_t)) rx_fifo_inst (
        .clk, .rst,
        .wr_valid(beat_wr_valid), .wr_ready(beat_wr_ready), .wr_data(beat_wr_data),
        .rd_valid(rx_valid), .rd_ready(rx_ready), .rd_data(beat_rd_data)
    );

endmodule

`default_nettype wire

/* verification/eth_props.sv */
`default_nettype none
`timescale 1ns/1ps
`include "eth_macros.svh"

module eth_props (
    input logic clk,
    input logic rst,
    input logic burst_req,
    input logic burst_ack,
    input logic tx_en,
    input logic frame_ok,
    input logic frame_err
);

    localparam int FRAME_LEN = `ETH_PREAMBLE_LEN + 1 + 2 + `ETH_PAYLOAD_LEN + 4;

    int run_len;   // Consecutive cycles with tx_en high so far

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            run_len <= 0;
        else if (tx_en)
            run_len <= run_len + 1;
        else
            run_len <= 0;
    end

    tx_run_exact: assert property (@(posedge clk) disable iff (rst)
        $fell(tx_en) |-> run_len == FRAME_LEN)
        else $error("tx_en frame ended after %0d cycles", run_len);

    tx_run_bound: assert property (@(posedge clk) disable iff (rst)
        tx_en |-> run_len < FRAME_LEN)
        else $error("tx_en stayed high past the frame length");

    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(burst_ack) |-> burst_req)
        else $error("burst_ack rose with burst_req low");

    status_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(frame_ok && frame_err))
        else $error("frame_ok and frame_err high together");

    // Outputs must come out of reset quiet
    quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !burst_ack && !tx_en && !frame_ok && !frame_err)
        else $error("an output was high right after reset released");

endmodule

bind eth_loopback_top eth_props eth_props_inst (
    .clk, .rst, .burst_req, .burst_ack, .tx_en, .frame_ok, .frame_err
);

`default_nettype wire

/* verification/eth_tb.sv */
`default_nettype none
`timescale 1ns/1ps
`include "eth_macros.svh"

module eth_tb import eth_pkg::*; ();

    localparam int HDR_LEN        = `ETH_PREAMBLE_LEN + 1 + 2;
    localparam int FRAME_WIRE_LEN = HDR_LEN + `ETH_PAYLOAD_LEN + 4;
    localparam int BURST_CYCLES   = `ETH_BURST_FRAMES *
                                    (FRAME_WIRE_LEN + `ETH_PAYLOAD_LEN + `ETH_GAP_CYCLES + 10);
    localparam int WATCHDOG_CYCLES = 2 * 5 * BURST_CYCLES;

    logic  clk;
    logic  rst;
    logic  burst_req;
    logic  burst_ack;
    byte_t pattern_base;
    byte_t txd;
    logic  tx_en;
    byte_t rxd;
    logic  rx_dv;
    byte_t rx_data;
    logic  rx_last;
    logic  rx_valid;
    logic  rx_ready;
    logic  frame_ok;
    logic  frame_err;

    int    mismatches;
    int    timeouts;
    int    corrupt_index;   // Wire byte of the burst to flip or -1 for none
    int    tx_count;
    logic  random_stall;
    byte_t got_data[$];
    logic  got_last[$];
    logic  got_ok[$];
    byte_t tx_bytes[$];

    eth_loopback_top eth_loopback_top_inst (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ########################################
    // Loopback, stalls and receive monitor
    // ########################################

    always @(negedge clk) begin
        if (tx_en) begin
            rxd = (tx_count == corrupt_index) ? txd ^ 8'h01 : txd;
            tx_bytes.push_back(txd);
            tx_count++;
        end else begin
            rxd = 8'h00;
        end
        rx_dv = tx_en;
    end

    always @(negedge clk) begin
        if (random_stall) rx_ready = $urandom_range(3) != 0;   // Low about one cycle in four
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (rx_valid && rx_ready) begin
                got_data.push_back(rx_data);
                got_last.push_back(rx_last);
            end
            if (frame_ok || frame_err) got_ok.push_back(frame_ok);
        end
    end

    task automatic report_mismatch(input string msg);
        mismatches++;
        $display("CHECK FAILED at %0d ns: %s", $time, msg);
    endtask

    task automatic report_timeout(input string msg);
        timeouts++;
        $display("Timeout at %0d ns: %s", $time, msg);
    endtask

    function automatic byte_t pattern_byte(input byte_t base, input int frame, input int idx);
        return byte_t'(int'(base) + frame * `ETH_PAYLOAD_LEN + idx);
    endfunction

    // ########################################
    // Burst handshake and drain
    // ########################################

    task automatic run_burst(input byte_t base);
        int waited;
        @(negedge clk);
        pattern_base = base;
        tx_count = 0;
        tx_bytes.delete();
        burst_req = 1'b1;
        waited = 0;
        while (!burst_ack && waited < 2 * BURST_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (!burst_ack) report_timeout("burst_ack never rose after burst_req");
        repeat (3) begin
            @(negedge clk);
            if (!burst_ack) report_mismatch("burst_ack dropped while burst_req was high");
        end
        burst_req = 1'b0;
        waited = 0;
        while (burst_ack && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (burst_ack) report_timeout("burst_ack stayed high after burst_req fell");
    endtask

    task automatic wait_drain();
        int idle;
        int waited;
        idle = 0;
        waited = 0;
        while (idle < 4 && waited < 400) begin
            @(negedge clk);
            waited++;
            idle = rx_valid ? 0 : idle + 1;
        end
        if (idle < 4) report_timeout("rx FIFO never ran empty");
    endtask

    // Bit k of ok_mask set means frame k should end with frame_ok
    task automatic check_status(input logic [3:0] ok_mask);
        if (got_ok.size() != `ETH_BURST_FRAMES) begin
            report_mismatch($sformatf("got %0d status pulses, expected %0d",
                                      got_ok.size(), `ETH_BURST_FRAMES));
        end else begin
            for (int k = 0; k < `ETH_BURST_FRAMES; k++)
                if (got_ok[k] != ok_mask[k])
                    report_mismatch($sformatf("frame %0d status ok=%b, expected %b",
                                              k, got_ok[k], ok_mask[k]));
        end
        got_ok.delete();
    endtask

    task automatic check_payload(input byte_t base, input int frames,
                                 input int bad_frame, input int bad_byte);
        byte_t exp;
        int    total;
        int    n;
        total = frames * `ETH_PAYLOAD_LEN;
        if (got_data.size() != total)
            report_mismatch($sformatf("received %0d bytes, expected %0d", got_data.size(), total));
        n = (got_data.size() < total) ? got_data.size() : total;
        for (int j = 0; j < n; j++) begin
            exp = pattern_byte(base, j / `ETH_PAYLOAD_LEN, j % `ETH_PAYLOAD_LEN);
            if (j / `ETH_PAYLOAD_LEN == bad_frame && j % `ETH_PAYLOAD_LEN == bad_byte)
                exp = exp ^ 8'h01;
            if (got_data[j] != exp)
                report_mismatch($sformatf("byte %0d is %h, expected %h", j, got_data[j], exp));
            if (got_last[j] != (j % `ETH_PAYLOAD_LEN == `ETH_PAYLOAD_LEN - 1))
                report_mismatch($sformatf("byte %0d has rx_last=%b", j, got_last[j]));
        end
        got_data.delete();
        got_last.delete();
    endtask

    task automatic check_wire_format(input byte_t base);
        int off;
        if (tx_bytes.size() != `ETH_BURST_FRAMES * FRAME_WIRE_LEN) begin
            report_mismatch($sformatf("%0d bytes on txd for the burst", tx_bytes.size()));
            return;
        end
        for (int k = 0; k < `ETH_BURST_FRAMES; k++) begin
            off = k * FRAME_WIRE_LEN;
            for (int i = 0; i < `ETH_PREAMBLE_LEN; i++)
                if (tx_bytes[off + i] != 8'h55)
                    report_mismatch($sformatf("frame %0d preamble byte %0d wrong", k, i));
            if (tx_bytes[off + `ETH_PREAMBLE_LEN] != 8'hD5)
                report_mismatch($sformatf("frame %0d has no SFD", k));
            if (tx_bytes[off + HDR_LEN - 2] != byte_t'(`ETH_PAYLOAD_LEN >> 8) ||
                tx_bytes[off + HDR_LEN - 1] != byte_t'(`ETH_PAYLOAD_LEN))
                report_mismatch($sformatf("frame %0d length field wrong", k));
            for (int i = 0; i < `ETH_PAYLOAD_LEN; i++)
                if (tx_bytes[off + HDR_LEN + i] != pattern_byte(base, k, i))
                    report_mismatch($sformatf("frame %0d txd payload byte %0d wrong", k, i));
        end
    endtask

    // ########################################
    // Directed tests
    // ########################################

    task automatic test_reset();
        repeat (20) begin
            @(negedge clk);
            if (burst_ack || tx_en || rx_valid || frame_ok || frame_err)
                report_mismatch($sformatf("idle outputs ack=%b tx_en=%b valid=%b ok=%b err=%b",
                                          burst_ack, tx_en, rx_valid, frame_ok, frame_err));
        end
    endtask

    task automatic test_single_burst();
        rx_ready = 1'b1;
        run_burst(8'h10);
        wait_drain();
        check_wire_format(8'h10);
        check_status(4'b1111);
        check_payload(8'h10, 4, -1, -1);
    endtask

    task automatic test_corrupt_frame();
        corrupt_index = 2 * FRAME_WIRE_LEN + HDR_LEN + 5;   // Payload byte 5 of frame 2
        run_burst(8'h40);
        corrupt_index = -1;
        wait_drain();
        check_status(4'b1011);
        check_payload(8'h40, 4, 2, 5);
    endtask

    task automatic test_backpressure();
        @(negedge clk);
        rx_ready = 1'b0;
        run_burst(8'hA0);
        if (!rx_valid)
            report_mismatch("rx_valid low after a burst received with rx_ready held low");
        check_status(4'b0011);
        @(negedge clk);
        rx_ready = 1'b1;
        wait_drain();
        check_payload(8'hA0, 2, -1, -1);
    endtask

    task automatic test_random_bursts();
        byte_t base;
        repeat (3) begin
            base = byte_t'($urandom_range(255));
            random_stall = 1'b1;
            run_burst(base);
            wait_drain();
            random_stall = 1'b0;
            rx_ready = 1'b1;
            check_status(4'b1111);
            check_payload(base, 4, -1, -1);
        end
    endtask

    initial begin
        void'($urandom(83477));
        mismatches    = 0;
        timeouts      = 0;
        corrupt_index = -1;
        tx_count      = 0;
        random_stall  = 1'b0;
        rst           = 1'b1;
        burst_req     = 1'b0;
        pattern_base  = 8'h00;
        rxd           = 8'h00;
        rx_dv         = 1'b0;
        rx_ready      = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_reset();
        test_single_burst();
        test_corrupt_frame();
        test_backpressure();
        test_random_bursts();

        $display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+design
design/eth_pkg.sv
design/byte_fifo.sv
design/payload_filler.sv
design/mac_tx.sv
design/mac_rx.sv
design/burst_sequencer.sv
design/eth_loopback_top.sv
verification/eth_props.sv
verification/eth_tb.sv

/* Makefile */
SOURCES := $(wildcard design/*.sv design/*.svh verification/*.sv)

.PHONY: run clean

run: obj_dir/Veth_tb
	obj_dir/Veth_tb | tee sim.log
	grep -q '^=== PASS ===$$' sim.log

obj_dir/Veth_tb: verilog.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module eth_tb -f verilog.f -o Veth_tb

clean:
	rm -rf obj_dir sim.log
